// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = nn_enc_tb
FILELIST  = nn_enc.f
OBJDIR    = obj_dir

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJDIR)

// ==== hdl/apb_regs.sv ====
// apb register block of the encoder
// control, status, input and output words, and the parameter write window
`timescale 1ns/1ps
`default_nettype none
`include "nn_enc_macros.svh"

module apb_regs (
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire nn_enc_pkg::apb_req_t               apb_req,
    output nn_enc_pkg::apb_rsp_t                    apb_rsp,
    output nn_enc_pkg::mem_wr_t                     mem_wr,
    output logic                                    start,
    output nn_enc_pkg::q_t [`NN_L1_IN-1:0]          x_vec,
    input  wire logic                               l1_ready,
    input  wire logic                               l1_busy,
    input  wire logic                               l2_busy,
    input  wire logic                               y_done,
    input  wire nn_enc_pkg::q_t [`NN_L2_OUT-1:0]    y_vec
);
    import nn_enc_pkg::*;

    localparam int XI_W = $clog2(`NN_L1_IN);
    localparam int YI_W = $clog2(`NN_L2_OUT);

    logic                   wr_en;
    logic                   rd_en;
    logic [`NN_APB_AW-1:0]  x_off;
    logic [`NN_APB_AW-1:0]  y_off;
    logic [`NN_APB_AW-1:0]  p_off;
    logic                   x_hit;
    logic                   y_hit;
    logic                   p_hit;
    lane_t                  p_lane;
    q_t [`NN_L2_OUT-1:0]    y_q;
    logic                   res_valid;

    // access phase, pready always high
    assign wr_en = apb_req.psel & apb_req.penable & apb_req.pwrite;
    assign rd_en = apb_req.psel & ~apb_req.pwrite;

    // word offsets inside each window
    assign x_off = apb_req.paddr - `NN_A_X;
    assign y_off = apb_req.paddr - `NN_A_Y;
    assign p_off = apb_req.paddr - `NN_A_PARAM;
    assign x_hit = (apb_req.paddr >= `NN_A_X) && (x_off < 4 * `NN_L1_IN);
    assign y_hit = (apb_req.paddr >= `NN_A_Y) && (y_off < 4 * `NN_L2_OUT);
    assign p_hit = (apb_req.paddr >= `NN_A_PARAM) && (p_off < (32 << `NN_ROW_W));

    // param address = base + row*32 + lane*4
    assign p_lane = p_off[2 +: $bits(lane_t)];

    always_comb begin
        mem_wr.valid = wr_en & p_hit & (p_lane < `NN_LANES);
        mem_wr.row   = p_off[5 +: `NN_ROW_W];
        mem_wr.lane  = p_lane;
        mem_wr.data  = apb_req.pwdata[`NN_DATA_W-1:0];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start     <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            // start dropped while layer 1 is busy
            start <= wr_en && (apb_req.paddr == `NN_A_CTRL) && apb_req.pwdata[0] && l1_ready;
            // a fresh result beats the clear
            if (y_done)
                res_valid <= 1'b1;
            else if (start)
                res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && x_hit)
            x_vec[x_off[2 +: XI_W]] <= apb_req.pwdata[`NN_DATA_W-1:0];
        if (y_done)
            y_q <= y_vec;
    end

    // read mux, unmapped reads return zero
    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = 1'b0;
        if (rd_en) begin
            if (apb_req.paddr == `NN_A_STATUS)
                apb_rsp.prdata[2:0] = {res_valid, l2_busy, l1_busy};
            else if (x_hit)
                apb_rsp.prdata[`NN_DATA_W-1:0] = x_vec[x_off[2 +: XI_W]];
            else if (y_hit)
                apb_rsp.prdata[`NN_DATA_W-1:0] = y_q[y_off[2 +: YI_W]];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dense_layer.sv ====
// one dense layer, N_IN inputs to N_OUT outputs
// fetches bias then weight rows from the shared memory, one mac lane per output
`timescale 1ns/1ps
`default_nettype none
`include "nn_enc_macros.svh"

module dense_layer #(
    parameter int N_IN  = `NN_L1_IN,
    parameter int N_OUT = `NN_L1_OUT,
    parameter int W_ROW = `NN_L1_W_ROW,
    parameter int B_ROW = `NN_L1_B_ROW
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       start,
    output logic                            ready,
    output logic                            busy,
    input  wire nn_enc_pkg::q_t [N_IN-1:0]  x_vec,
    output nn_enc_pkg::mem_rd_req_t         rd_req,
    input  wire logic                       gnt,
    input  wire logic                       rd_valid,
    input  wire nn_enc_pkg::row_t           rd_data,
    output logic                            done,
    input  wire logic                       done_ack,
    output nn_enc_pkg::q_t [N_OUT-1:0]      y_vec
);
    import nn_enc_pkg::*;

    // row counter: 0 is the bias row, k is weight row k-1
    localparam int CNT_W = $clog2(N_IN + 1);

    layer_state_t       state;
    logic [CNT_W-1:0]   cnt;
    logic               done_q;
    logic               accept;
    q_t [N_IN-1:0]      x_q;
    logic               tag_bias;
    logic [CNT_W-1:0]   tag_idx;
    q_t                 x_sel;
    logic               lane_load;
    logic               lane_acc;

    assign ready = (state == IDLE);
    assign busy  = (state != IDLE);
    assign done  = done_q;

    // request held steady until granted
    always_comb begin
        rd_req.valid = (state == FETCH);
        if (cnt == '0)
            rd_req.row = row_addr_t'(B_ROW);
        else
            rd_req.row = row_addr_t'(W_ROW) + row_addr_t'(cnt) - row_addr_t'(1);
    end

    assign accept = rd_req.valid & gnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= IDLE;
            cnt    <= '0;
            done_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= FETCH;
                        cnt   <= '0;
                    end
                end
                FETCH: begin
                    // last weight row granted, only its data is still due
                    if (accept && cnt == CNT_W'(N_IN)) begin
                        state <= DRAIN;
                        cnt   <= '0;
                    end else if (accept) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DRAIN: begin
                    if (rd_valid)
                        done_q <= 1'b1;
                    // hold done until the consumer takes it
                    if (done_q && done_ack) begin
                        done_q <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // input capture and tag of the row in flight
    always_ff @(posedge clk) begin
        if (ready && start)
            x_q <= x_vec;
        if (accept) begin
            tag_bias <= (cnt == '0);
            tag_idx  <= (cnt == '0) ? '0 : cnt - 1'b1;
        end
    end

    assign x_sel     = x_q[tag_idx];
    assign lane_load = rd_valid & tag_bias;
    assign lane_acc  = rd_valid & ~tag_bias;

    // lane i takes weight i of each row
    for (genvar i = 0; i < N_OUT; i++) begin : g_lane
        fixed_point_mac u_mac (
            .clk    (clk),
            .reset  (reset),
            .load   (lane_load),
            .acc_en (lane_acc),
            .bias   (rd_data[i]),
            .a      (x_sel),
            .b      (rd_data[i]),
            .acc    (y_vec[i])
        );
    end

endmodule

`default_nettype wire

// ==== hdl/fixed_point_mac.sv ====
// saturating q8.8 multiply-accumulate lane
// the accumulator loads a bias, then adds one saturated product per enable
`timescale 1ns/1ps
`default_nettype none
`include "nn_enc_macros.svh"

module fixed_point_mac (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           load,
    input  wire logic           acc_en,
    input  wire nn_enc_pkg::q_t bias,
    input  wire nn_enc_pkg::q_t a,
    input  wire nn_enc_pkg::q_t b,
    output nn_enc_pkg::q_t      acc
);
    import nn_enc_pkg::*;

    localparam int PROD_W = 2 * `NN_DATA_W;
    localparam q_t Q_POS = {1'b0, {(`NN_DATA_W-1){1'b1}}};
    localparam q_t Q_NEG = {1'b1, {(`NN_DATA_W-1){1'b0}}};

    logic signed [PROD_W-1:0]     prod_full;
    logic signed [PROD_W-1:0]     prod_shift;
    q_t                           prod_sat;
    logic signed [`NN_DATA_W:0]   sum_wide;
    q_t                           sum_sat;

    // full signed product, back to q8.8 scale
    assign prod_full  = a * b;
    assign prod_shift = prod_full >>> `NN_FRAC_W;

    // clamp the product to 16 bits
    always_comb begin
        if (prod_shift > Q_POS)
            prod_sat = Q_POS;
        else if (prod_shift < Q_NEG)
            prod_sat = Q_NEG;
        else
            prod_sat = prod_shift[`NN_DATA_W-1:0];
    end

    // one guard bit catches the overflow of the add
    assign sum_wide = acc + prod_sat;

    always_comb begin
        if (sum_wide[`NN_DATA_W] != sum_wide[`NN_DATA_W-1])
            sum_sat = sum_wide[`NN_DATA_W] ? Q_NEG : Q_POS;
        else
            sum_sat = sum_wide[`NN_DATA_W-1:0];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc <= '0;
        end else if (load) begin
            acc <= bias;
        end else if (acc_en) begin
            acc <= sum_sat;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/nn_enc_pkg.sv ====
// shared types of the neural encoder
// q8.8 values, memory rows, apb and memory command structs, layer fsm states
`default_nettype none
`include "nn_enc_macros.svh"

package nn_enc_pkg;

    // signed q8.8 value
    typedef logic signed [`NN_DATA_W-1:0] q_t;
    typedef logic [`NN_ROW_W-1:0] row_addr_t;
    typedef logic [$clog2(`NN_LANES)-1:0] lane_t;

    // one memory row, lane i feeds output i
    typedef q_t [`NN_LANES-1:0] row_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`NN_APB_AW-1:0]  paddr;
        logic [`NN_APB_DW-1:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`NN_APB_DW-1:0]  prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // single-lane write from the register block
    typedef struct packed {
        logic       valid;
        row_addr_t  row;
        lane_t      lane;
        q_t         data;
    } mem_wr_t;

    // row read request from a layer
    typedef struct packed {
        logic       valid;
        row_addr_t  row;
    } mem_rd_req_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DRAIN
    } layer_state_t;

endpackage

`default_nettype wire

// ==== hdl/nn_enc_top.sv ====
// neural encoder top, two dense layers sharing one parameter ram behind apb
`timescale 1ns/1ps
`default_nettype none
`include "nn_enc_macros.svh"

module nn_enc_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire nn_enc_pkg::apb_req_t   apb_req,
    output nn_enc_pkg::apb_rsp_t        apb_rsp
);
    import nn_enc_pkg::*;

    mem_wr_t                mem_wr;
    logic                   l1_start;
    q_t [`NN_L1_IN-1:0]     x_vec;
    logic                   l1_ready;
    logic                   l1_busy;
    logic                   l2_ready;
    logic                   l2_busy;
    mem_rd_req_t            l1_req;
    mem_rd_req_t            l2_req;
    logic                   l1_gnt;
    logic                   l2_gnt;
    logic                   l1_rd_valid;
    logic                   l2_rd_valid;
    logic                   ram_we;
    lane_t                  ram_lane;
    row_addr_t              ram_addr;
    q_t                     ram_wdata;
    row_t                   ram_rdata;
    row_t                   rd_data;
    logic                   l1_done;
    logic                   l2_done;
    q_t [`NN_L1_OUT-1:0]    l1_y;
    q_t [`NN_L2_OUT-1:0]    l2_y;

    apb_regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .mem_wr   (mem_wr),
        .start    (l1_start),
        .x_vec    (x_vec),
        .l1_ready (l1_ready),
        .l1_busy  (l1_busy),
        .l2_busy  (l2_busy),
        .y_done   (l2_done),
        .y_vec    (l2_y)
    );

    param_mem_arbiter u_arb (
        .clk         (clk),
        .reset       (reset),
        .mem_wr      (mem_wr),
        .l1_req      (l1_req),
        .l2_req      (l2_req),
        .l1_gnt      (l1_gnt),
        .l2_gnt      (l2_gnt),
        .l1_rd_valid (l1_rd_valid),
        .l2_rd_valid (l2_rd_valid),
        .ram_we      (ram_we),
        .ram_lane    (ram_lane),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata),
        .rd_data     (rd_data)
    );

    param_mem u_mem (
        .clk   (clk),
        .we    (ram_we),
        .lane  (ram_lane),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    // layer 1 holds done until layer 2 is idle
    dense_layer #(
        .N_IN  (`NN_L1_IN),
        .N_OUT (`NN_L1_OUT),
        .W_ROW (`NN_L1_W_ROW),
        .B_ROW (`NN_L1_B_ROW)
    ) u_layer1 (
        .clk      (clk),
        .reset    (reset),
        .start    (l1_start),
        .ready    (l1_ready),
        .busy     (l1_busy),
        .x_vec    (x_vec),
        .rd_req   (l1_req),
        .gnt      (l1_gnt),
        .rd_valid (l1_rd_valid),
        .rd_data  (rd_data),
        .done     (l1_done),
        .done_ack (l2_ready),
        .y_vec    (l1_y)
    );

    // the register block always takes the result
    dense_layer #(
        .N_IN  (`NN_L2_IN),
        .N_OUT (`NN_L2_OUT),
        .W_ROW (`NN_L2_W_ROW),
        .B_ROW (`NN_L2_B_ROW)
    ) u_layer2 (
        .clk      (clk),
        .reset    (reset),
        .start    (l1_done),
        .ready    (l2_ready),
        .busy     (l2_busy),
        .x_vec    (l1_y),
        .rd_req   (l2_req),
        .gnt      (l2_gnt),
        .rd_valid (l2_rd_valid),
        .rd_data  (rd_data),
        .done     (l2_done),
        .done_ack (1'b1),
        .y_vec    (l2_y)
    );

endmodule

`default_nettype wire

// ==== hdl/param_mem.sv ====
// row-wide parameter ram, registered read, single lane write
`timescale 1ns/1ps
`default_nettype none
`include "nn_enc_macros.svh"

module param_mem (
    input  wire logic                   clk,
    input  wire logic                   we,
    input  wire nn_enc_pkg::lane_t      lane,
    input  wire nn_enc_pkg::row_addr_t  addr,
    input  wire nn_enc_pkg::q_t         wdata,
    output nn_enc_pkg::row_t            rdata
);
    import nn_enc_pkg::*;

    localparam int DEPTH = 1 << `NN_ROW_W;

    // contents undefined until the host loads them
    row_t mem [DEPTH];

    always_ff @(posedge clk) begin
        // only the addressed lane changes
        if (we)
            mem[addr][lane] <= wdata;
        // read every cycle, data valid one cycle later
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== hdl/param_mem_arbiter.sv ====
// parameter memory port arbiter
// host writes first, then round-robin between the two layers, read data tagged by owner
`timescale 1ns/1ps
`default_nettype none

module param_mem_arbiter (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire nn_enc_pkg::mem_wr_t        mem_wr,
    input  wire nn_enc_pkg::mem_rd_req_t    l1_req,
    input  wire nn_enc_pkg::mem_rd_req_t    l2_req,
    output logic                            l1_gnt,
    output logic                            l2_gnt,
    output logic                            l1_rd_valid,
    output logic                            l2_rd_valid,
    output logic                            ram_we,
    output nn_enc_pkg::lane_t               ram_lane,
    output nn_enc_pkg::row_addr_t           ram_addr,
    output nn_enc_pkg::q_t                  ram_wdata,
    input  wire nn_enc_pkg::row_t           ram_rdata,
    output nn_enc_pkg::row_t                rd_data
);

    logic prefer_l2;
    logic rd_pend;
    // owner of the pending read, 1 for layer 2
    logic rd_owner;

    // a write blocks both layers for that cycle
    assign l1_gnt = ~mem_wr.valid & l1_req.valid & (~l2_req.valid | ~prefer_l2);
    assign l2_gnt = ~mem_wr.valid & l2_req.valid & (~l1_req.valid | prefer_l2);

    assign ram_we    = mem_wr.valid;
    assign ram_lane  = mem_wr.lane;
    assign ram_wdata = mem_wr.data;

    always_comb begin
        if (mem_wr.valid)
            ram_addr = mem_wr.row;
        else if (l2_gnt)
            ram_addr = l2_req.row;
        else
            ram_addr = l1_req.row;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prefer_l2 <= 1'b0;
            rd_pend   <= 1'b0;
            rd_owner  <= 1'b0;
        end else begin
            // pass priority to the other layer after each grant
            if (l1_gnt)
                prefer_l2 <= 1'b1;
            else if (l2_gnt)
                prefer_l2 <= 1'b0;
            rd_pend  <= l1_gnt | l2_gnt;
            rd_owner <= l2_gnt;
        end
    end

    // registered ram output lines up with the tag
    assign l1_rd_valid = rd_pend & ~rd_owner;
    assign l2_rd_valid = rd_pend & rd_owner;
    assign rd_data     = ram_rdata;

endmodule

`default_nettype wire

// ==== include/nn_enc_macros.svh ====
// width, layer size, row map and register map constants for the neural encoder
`ifndef NN_ENC_MACROS_SVH
`define NN_ENC_MACROS_SVH

// q8.8 number format
`define NN_DATA_W 16
`define NN_FRAC_W 8

// parameter memory geometry, one lane per output
`define NN_LANES 6
`define NN_ROW_W 5

// layer shapes
`define NN_L1_IN  10
`define NN_L1_OUT 6
`define NN_L2_IN  6
`define NN_L2_OUT 3

// row map of the parameter memory
`define NN_L1_W_ROW 0
`define NN_L1_B_ROW 10
`define NN_L2_W_ROW 11
`define NN_L2_B_ROW 17

// apb bus and register map
`define NN_APB_AW   12
`define NN_APB_DW   32
`define NN_A_CTRL   12'h000
`define NN_A_STATUS 12'h004
`define NN_A_X      12'h040
`define NN_A_Y      12'h080
`define NN_A_PARAM  12'h400

`endif

// ==== nn_enc.f ====
+incdir+include
hdl/nn_enc_pkg.sv
hdl/fixed_point_mac.sv
hdl/dense_layer.sv
hdl/param_mem_arbiter.sv
hdl/param_mem.sv
hdl/apb_regs.sv
hdl/nn_enc_top.sv
testbench/nn_enc_tb.sv

// ==== testbench/nn_enc_tb.sv ====
// testbench of the neural encoder
// directed apb tests against a q8.8 reference model of both dense layers
`timescale 1ns/1ps
`default_nettype none
`include "nn_enc_macros.svh"

module nn_enc_tb;
    import nn_enc_pkg::*;

    localparam int CLK_NS     = 4;
    localparam int APB_CYCLES = 3;
    localparam int POLL_LIMIT = 100;
    // apb transfers of one full parameter load
    localparam int N_PARAMS = `NN_L1_IN * `NN_L1_OUT + `NN_L1_OUT
                            + `NN_L2_IN * `NN_L2_OUT + `NN_L2_OUT;
    localparam int LOAD_CYCLES = APB_CYCLES * N_PARAMS;
    // inputs, start, worst polling, outputs
    localparam int RUN_CYCLES = APB_CYCLES * (`NN_L1_IN + 1 + POLL_LIMIT + `NN_L2_OUT);
    localparam int N_LOADS = 5;
    localparam int N_RUNS  = 10;
    localparam int WATCHDOG_NS = 2 * (N_LOADS * LOAD_CYCLES + N_RUNS * RUN_CYCLES + 100) * CLK_NS;

    logic     clk;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    integer seed = 32'hd545_c006;
    int     errors = 0;
    int     checks = 0;

    // reference model state
    logic [15:0] w1 [`NN_L1_IN][`NN_L1_OUT];
    logic [15:0] b1 [`NN_L1_OUT];
    logic [15:0] w2 [`NN_L2_IN][`NN_L2_OUT];
    logic [15:0] b2 [`NN_L2_OUT];
    logic [15:0] x_cur [`NN_L1_IN];
    logic [15:0] h_exp [`NN_L1_OUT];
    logic [15:0] y_exp [`NN_L2_OUT];
    logic [15:0] y_act [`NN_L2_OUT];

    nn_enc_top i_nn_enc_top (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // q8.8 arithmetic of the model
    function automatic logic [15:0] clamp_q(input longint v);
        if (v > 32767)
            return 16'h7fff;
        else if (v < -32768)
            return 16'h8000;
        return 16'(v);
    endfunction

    function automatic logic [15:0] mul_q(input logic [15:0] a, input logic [15:0] b);
        longint pa;
        longint pb;
        pa = longint'($signed(a));
        pb = longint'($signed(b));
        // arithmetic shift drops the fraction bits toward minus infinity
        return clamp_q((pa * pb) >>> `NN_FRAC_W);
    endfunction

    function automatic logic [15:0] add_q(input logic [15:0] a, input logic [15:0] b);
        return clamp_q(longint'($signed(a)) + longint'($signed(b)));
    endfunction

    // signed value with the given number of significant bits
    function automatic logic [15:0] rand_q(input int bits);
        logic signed [15:0] r;
        r = 16'($random(seed));
        return r >>> (16 - bits);
    endfunction

    // bias first, then inputs in index order
    function automatic void model_forward();
        logic [15:0] acc;
        for (int o = 0; o < `NN_L1_OUT; o++) begin
            acc = b1[o];
            for (int i = 0; i < `NN_L1_IN; i++)
                acc = add_q(acc, mul_q(x_cur[i], w1[i][o]));
            h_exp[o] = acc;
        end
        for (int o = 0; o < `NN_L2_OUT; o++) begin
            acc = b2[o];
            for (int i = 0; i < `NN_L2_IN; i++)
                acc = add_q(acc, mul_q(h_exp[i], w2[i][o]));
            y_exp[o] = acc;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // setup, access, then back to idle
    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b1;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
        apb_req.paddr   <= addr;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // read data settled mid access phase
        @(negedge clk);
        data = apb_rsp.prdata;
        // no wait states and no error responses
        check_value($sformatf("apb read %h handshake", addr), 32'h2,
                    {30'h0, apb_rsp.pready, apb_rsp.pslverr});
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic wait_status(input string name, input logic [2:0] mask,
                               input logic [2:0] want, output logic [2:0] st);
        logic [31:0] rd;
        int          n;
        n = 0;
        do begin
            apb_read(`NN_A_STATUS, rd);
            st = rd[2:0];
            n++;
        end while ((st & mask) != want && n < POLL_LIMIT);
        if ((st & mask) != want) begin
            errors++;
            $display("%s: status never reached %b under mask %b, last read %b",
                     name, want, mask, st);
        end
    endtask

    // row*32 + lane*4 above the window base
    task automatic write_param(input int row, input int lane, input logic [15:0] val);
        apb_write(12'(`NN_A_PARAM + row * 32 + lane * 4), {16'h0, val});
    endtask

    task automatic load_params();
        for (int i = 0; i < `NN_L1_IN; i++)
            for (int o = 0; o < `NN_L1_OUT; o++)
                write_param(`NN_L1_W_ROW + i, o, w1[i][o]);
        for (int o = 0; o < `NN_L1_OUT; o++)
            write_param(`NN_L1_B_ROW, o, b1[o]);
        for (int i = 0; i < `NN_L2_IN; i++)
            for (int o = 0; o < `NN_L2_OUT; o++)
                write_param(`NN_L2_W_ROW + i, o, w2[i][o]);
        for (int o = 0; o < `NN_L2_OUT; o++)
            write_param(`NN_L2_B_ROW, o, b2[o]);
    endtask

    task automatic write_inputs(input int first, input int count);
        for (int i = first; i < first + count; i++)
            apb_write(12'(`NN_A_X + 4 * i), {16'h0, x_cur[i]});
    endtask

    task automatic read_outputs();
        logic [31:0] rd;
        for (int k = 0; k < `NN_L2_OUT; k++) begin
            apb_read(12'(`NN_A_Y + 4 * k), rd);
            y_act[k] = rd[15:0];
        end
    endtask

    task automatic check_outputs(input string name);
        for (int k = 0; k < `NN_L2_OUT; k++)
            check_value($sformatf("%s y[%0d]", name, k), {16'h0, y_exp[k]}, {16'h0, y_act[k]});
    endtask

    // full vector through the encoder and compared with the model
    task automatic run_vector(input string name);
        logic [2:0] st;
        write_inputs(0, `NN_L1_IN);
        model_forward();
        apb_write(`NN_A_CTRL, 32'h1);
        wait_status(name, 3'b111, 3'b100, st);
        read_outputs();
        check_outputs(name);
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        logic [11:0] unmapped [7];
        apb_read(`NN_A_STATUS, rd);
        check_value("reset status", 32'h0, rd);
        for (int i = 0; i < `NN_L1_IN; i++)
            x_cur[i] = rand_q(16);
        write_inputs(0, `NN_L1_IN);
        for (int i = 0; i < `NN_L1_IN; i++) begin
            apb_read(12'(`NN_A_X + 4 * i), rd);
            check_value($sformatf("readback x[%0d]", i), {16'h0, x_cur[i]}, rd);
        end
        // ctrl, gaps around the windows, and the write-only parameter window
        unmapped = '{12'h000, 12'h008, 12'h03c, 12'h068, 12'h08c, 12'h400, 12'hffc};
        foreach (unmapped[k]) begin
            apb_read(unmapped[k], rd);
            check_value($sformatf("unmapped %h", unmapped[k]), 32'h0, rd);
        end
    endtask

    task automatic test_identity();
        logic [31:0] rd;
        foreach (w1[i, o])
            w1[i][o] = (i == o) ? 16'h0100 : 16'h0000;
        foreach (w2[i, o])
            w2[i][o] = (i == o) ? 16'h0100 : 16'h0000;
        foreach (b1[o])
            b1[o] = '0;
        foreach (b2[o])
            b2[o] = '0;
        load_params();
        for (int i = 0; i < `NN_L1_IN; i++)
            x_cur[i] = rand_q(16);
        run_vector("identity");
        // unit diagonal passes the first inputs straight through
        for (int k = 0; k < `NN_L2_OUT; k++)
            check_value($sformatf("identity x pass y[%0d]", k), {16'h0, x_cur[k]},
                        {16'h0, y_act[k]});
        apb_read(`NN_A_STATUS, rd);
        check_value("identity final status", 32'h4, rd);
    endtask

    task automatic test_bias_only();
        foreach (w1[i, o])
            w1[i][o] = '0;
        foreach (w2[i, o])
            w2[i][o] = '0;
        foreach (b1[o])
            b1[o] = rand_q(16);
        foreach (b2[o])
            b2[o] = rand_q(16);
        load_params();
        for (int i = 0; i < `NN_L1_IN; i++)
            x_cur[i] = rand_q(16);
        run_vector("bias only");
        for (int k = 0; k < `NN_L2_OUT; k++)
            check_value($sformatf("bias only b2 y[%0d]", k), {16'h0, b2[k]}, {16'h0, y_act[k]});
    endtask

    task automatic test_random();
        // about plus or minus two so most sums stay in range
        foreach (w1[i, o])
            w1[i][o] = rand_q(10);
        foreach (w2[i, o])
            w2[i][o] = rand_q(10);
        foreach (b1[o])
            b1[o] = rand_q(10);
        foreach (b2[o])
            b2[o] = rand_q(10);
        load_params();
        for (int v = 0; v < 4; v++) begin
            for (int i = 0; i < `NN_L1_IN; i++)
                x_cur[i] = rand_q(10);
            run_vector($sformatf("random vector %0d", v));
        end
    endtask

    task automatic test_back_to_back();
        logic [2:0]  st;
        logic [15:0] y_first [`NN_L2_OUT];
        for (int i = 0; i < `NN_L1_IN; i++)
            x_cur[i] = rand_q(10);
        write_inputs(0, `NN_L1_IN);
        model_forward();
        y_first = y_exp;
        apb_write(`NN_A_CTRL, 32'h1);
        // layer 1 took its copy and the registers are free again
        for (int i = 0; i < 3; i++)
            x_cur[i] = rand_q(10);
        write_inputs(0, 3);
        model_forward();
        wait_status("b2b layer 1 idle", 3'b001, 3'b000, st);
        check_value("b2b layer 2 busy", 32'h1, {31'h0, st[1]});
        apb_write(`NN_A_CTRL, 32'h1);
        // first result shows up while the second vector is still in flight
        wait_status("b2b first", 3'b100, 3'b100, st);
        read_outputs();
        for (int k = 0; k < `NN_L2_OUT; k++)
            check_value($sformatf("b2b first y[%0d]", k), {16'h0, y_first[k]},
                        {16'h0, y_act[k]});
        wait_status("b2b second", 3'b111, 3'b100, st);
        read_outputs();
        check_outputs("b2b second");
    endtask

    task automatic test_saturation();
        foreach (w1[i, o])
            w1[i][o] = 16'h7fff;
        // lane 0 all positive, lane 1 all negative, lane 2 alternating
        foreach (w2[i, o]) begin
            if (o == 0)
                w2[i][o] = 16'h7fff;
            else if (o == 1)
                w2[i][o] = 16'h8000;
            else
                w2[i][o] = (i % 2 == 0) ? 16'h7fff : 16'h8000;
        end
        foreach (b1[o])
            b1[o] = rand_q(16);
        foreach (b2[o])
            b2[o] = rand_q(16);
        load_params();
        for (int i = 0; i < `NN_L1_IN; i++)
            x_cur[i] = 16'h7fff;
        run_vector("saturation");
        check_value("saturation clamp high", 32'h7fff, {16'h0, y_act[0]});
        check_value("saturation clamp low", 32'h8000, {16'h0, y_act[1]});
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        apb_req = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        test_identity();
        test_bias_only();
        test_random();
        test_back_to_back();
        test_saturation();
        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
